// File: Makefile
# Verilator build and run of the board testbench
TOP = tb_board_specific_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: board_cases.txt
# W addr data bresp wstrb stall | R addr data rresp stall | all fields hex
# M mic_word | D four hex nibbles (digit 0 lowest) dp_mask
R 00 00000000 0 0
R 04 00000000 0 0
R 08 00000000 0 0
R 0C 00000000 0 0
R 10 00000000 0 0
W 00 00001234 0 F 0
W 04 00000005 0 1 0
W 10 000000A5 0 1 3
R 00 00001234 0 0
R 04 00000005 0 0
R 10 000000A5 0 4
D 1234 5
W 00 0000BEEF 0 2 0
W 10 0000FF00 0 2 0
R 00 0000BE34 0 0
R 10 000000A5 0 0
D BE34 5
W 20 FFFFFFFF 2 F 2
W 0C FFFFFFFF 2 F 0
R 24 00000000 2 3
R 00 0000BE34 0 0
R 04 00000005 0 0
R 08 00000000 0 0
R 0C 00000000 0 0
M A5C31E
R 0C 00A5C31E 0 0
W 08 00000001 0 1 0
R 08 00000001 0 0
D A5C3 5

// File: board_pkg.sv
package board_pkg;

    // ------------------------------
    // Board widths
    // ------------------------------

    localparam int w_digit = 4;              // Dynamic display digits
    localparam int w_seg   = 8;              // Segments a..g plus dp
    localparam int w_led   = 8;              // Board LEDs
    localparam int w_mic   = 24;             // INMP441 sample width

    // ------------------------------
    // AXI4-Lite
    // ------------------------------

    localparam int w_axi_addr = 8;
    localparam int w_axi_data = 32;

    localparam logic [w_axi_addr - 1:0] addr_display = 8'h00;  // Four hex nibbles
    localparam logic [w_axi_addr - 1:0] addr_dp      = 8'h04;  // Decimal point mask
    localparam logic [w_axi_addr - 1:0] addr_source  = 8'h08;  // 0 register, 1 microphone
    localparam logic [w_axi_addr - 1:0] addr_mic     = 8'h0C;  // Last sample, read only
    localparam logic [w_axi_addr - 1:0] addr_led     = 8'h10;  // LED pattern

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    // ------------------------------
    // Timing
    // ------------------------------

    localparam int scan_div      = 4;        // Clocks per digit, short for simulation
    localparam int sck_div       = 2;        // Clocks per half period of sck
    localparam int i2s_slot_bits = 32;       // Bit clocks per channel slot

endpackage

// File: board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
(
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [board_pkg::w_axi_addr - 1:0]      awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [board_pkg::w_axi_data - 1:0]      wdata,
    input  logic [board_pkg::w_axi_data / 8 - 1:0]  wstrb,
    input  logic                                    wvalid,
    output logic                                    wready,
    output logic [1:0]                              bresp,
    output logic                                    bvalid,
    input  logic                                    bready,
    input  logic [board_pkg::w_axi_addr - 1:0]      araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [board_pkg::w_axi_data - 1:0]      rdata,
    output logic [1:0]                              rresp,
    output logic                                    rvalid,
    input  logic                                    rready,

    output logic [board_pkg::w_led - 1:0]           led,
    output logic [6:0]                              hex0,     // Active low, bit 0 is segment a
    output logic [6:0]                              hex1,
    output logic [6:0]                              hex2,
    output logic [6:0]                              hex3,
    output logic [board_pkg::w_digit - 1:0]         hex_dp,   // Active high

    output logic                                    mic_lr,
    output logic                                    mic_ws,
    output logic                                    mic_sck,
    input  logic                                    mic_sd
);

    logic [board_pkg::w_seg - 1:0]    abcdefgh;
    logic [board_pkg::w_seg - 1:0]    hgfedcba;
    logic [board_pkg::w_digit - 1:0]  digit;
    logic [6:0]                       hex_q [board_pkg::w_digit];

    lab_top lab_top_inst
    (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .led, .abcdefgh, .digit,
        .mic_lr, .mic_ws, .mic_sck, .mic_sd
    );

    // ------------------------------
    // Segment order and static HEX
    // ------------------------------

    always_comb
    begin
        for (int i = 0; i < board_pkg::w_seg; i++)
            hgfedcba[i] = abcdefgh[board_pkg::w_seg - 1 - i];   // a lands in bit 0
    end

    // Sticky flops keep each digit lit between its strobes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < board_pkg::w_digit; n++)
                hex_q[n] <= '1;                  // Blank
            hex_dp <= '0;
        end
        else
        begin
            for (int n = 0; n < board_pkg::w_digit; n++)
            begin
                if (digit[n])
                begin
                    hex_q[n]  <= ~hgfedcba[6:0];
                    hex_dp[n] <= hgfedcba[7];
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

// File: display_regs.sv
`timescale 1ns/1ps

module display_regs
(
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [board_pkg::w_axi_addr - 1:0]      awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [board_pkg::w_axi_data - 1:0]      wdata,
    input  logic [board_pkg::w_axi_data / 8 - 1:0]  wstrb,
    input  logic                                    wvalid,
    output logic                                    wready,
    output logic [1:0]                              bresp,
    output logic                                    bvalid,
    input  logic                                    bready,

    input  logic [board_pkg::w_axi_addr - 1:0]      araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [board_pkg::w_axi_data - 1:0]      rdata,
    output logic [1:0]                              rresp,
    output logic                                    rvalid,
    input  logic                                    rready,

    input  logic [board_pkg::w_mic - 1:0]           mic_value,
    output logic [4 * board_pkg::w_digit - 1:0]     display_value,
    output logic [board_pkg::w_digit - 1:0]         dp_mask,
    output logic                                    source_mic,
    output logic [board_pkg::w_led - 1:0]           led_value
);

    logic                                wr_fire;   // Address and data taken this cycle
    logic                                rd_fire;   // Read address taken this cycle
    logic                                wr_err;
    logic                                rd_err;
    logic [board_pkg::w_axi_data - 1:0]  rd_word;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    // ------------------------------
    // Address decode
    // ------------------------------

    assign wr_err = !(awaddr == board_pkg::addr_display || awaddr == board_pkg::addr_dp
                   || awaddr == board_pkg::addr_source || awaddr == board_pkg::addr_led);

    always_comb
    begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            board_pkg::addr_display: rd_word[4 * board_pkg::w_digit - 1:0] = display_value;
            board_pkg::addr_dp:      rd_word[board_pkg::w_digit - 1:0]     = dp_mask;
            board_pkg::addr_source:  rd_word[0]                            = source_mic;
            board_pkg::addr_mic:     rd_word[board_pkg::w_mic - 1:0]       = mic_value;
            board_pkg::addr_led:     rd_word[board_pkg::w_led - 1:0]       = led_value;
            default:                 rd_err                                = 1'b1;  // Unmapped, data stays 0
        endcase
    end

    // ------------------------------
    // Handshakes and registers
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            awready       <= 1'b0;
            wready        <= 1'b0;
            bvalid        <= 1'b0;
            arready       <= 1'b0;
            rvalid        <= 1'b0;
            display_value <= '0;
            dp_mask       <= '0;
            source_mic    <= 1'b0;
            led_value     <= '0;
        end
        else
        begin
            // One cycle ready pulse, only with no response pending
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            arready <= arvalid && !rvalid && !arready;

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;                   // Held until the master takes it

            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (wr_fire)
            begin
                case (awaddr)
                    board_pkg::addr_display:
                    begin
                        if (wstrb[0]) display_value[7:0]  <= wdata[7:0];
                        if (wstrb[1]) display_value[15:8] <= wdata[15:8];
                    end
                    board_pkg::addr_dp:
                        if (wstrb[0]) dp_mask <= wdata[board_pkg::w_digit - 1:0];
                    board_pkg::addr_source:
                        if (wstrb[0]) source_mic <= wdata[0];
                    board_pkg::addr_led:
                        if (wstrb[0]) led_value <= wdata[board_pkg::w_led - 1:0];
                    default: ;                    // Microphone and unmapped writes are dropped
                endcase
            end
        end
    end

    // Response payload, captured with the handshake
    always_ff @(posedge clk)
    begin
        if (wr_fire)
            bresp <= wr_err ? board_pkg::resp_slverr : board_pkg::resp_okay;
        if (rd_fire)
        begin
            rdata <= rd_word;
            rresp <= rd_err ? board_pkg::resp_slverr : board_pkg::resp_okay;
        end
    end

endmodule

// File: files.f
board_pkg.sv
display_regs.sv
seg7_scanner.sv
inmp441_mic_i2s_receiver.sv
lab_top.sv
board_specific_top.sv
tb_board_specific_top.sv

// File: inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
(
    input  logic                            clk,
    input  logic                            rst,
    output logic                            lr,
    output logic                            ws,
    output logic                            sck,
    input  logic                            sd,
    output logic [board_pkg::w_mic - 1:0]   value
);

    localparam int w_sck_cnt = $clog2(board_pkg::sck_div);
    localparam int w_bit_cnt = $clog2(board_pkg::i2s_slot_bits);

    logic [w_sck_cnt - 1:0]         sck_cnt;   // Clocks in the current sck half period
    logic [w_bit_cnt - 1:0]         bit_cnt;   // Bit clock index inside the slot
    logic                           sck_edge;
    logic                           sck_rise;
    logic                           sck_fall;
    logic                           capture;   // Data bit of the left slot
    logic [board_pkg::w_mic - 1:0]  shift;

    assign lr       = 1'b0;                    // Microphone answers in the left slot
    assign sck_edge = sck_cnt == w_sck_cnt'(board_pkg::sck_div - 1);
    assign sck_rise = sck_edge && !sck;
    assign sck_fall = sck_edge && sck;

    // Skip the one-bit I2S delay, then take 24 bits MSB first
    assign capture  = !ws && bit_cnt >= w_bit_cnt'(1)
                   && bit_cnt <= w_bit_cnt'(board_pkg::w_mic);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sck_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
            value   <= '0;
        end
        else
        begin
            sck_cnt <= sck_edge ? '0 : sck_cnt + 1'b1;
            if (sck_edge)
                sck <= !sck;

            if (sck_fall)
            begin
                if (bit_cnt == w_bit_cnt'(board_pkg::i2s_slot_bits - 1))
                begin
                    bit_cnt <= '0;
                    ws      <= !ws;           // Next channel slot
                    if (!ws)
                        value <= shift;       // Left word complete as ws rises
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise && capture)
            shift <= {shift[board_pkg::w_mic - 2:0], sd};
    end

endmodule

// File: lab_top.sv
`timescale 1ns/1ps

module lab_top
(
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [board_pkg::w_axi_addr - 1:0]      awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [board_pkg::w_axi_data - 1:0]      wdata,
    input  logic [board_pkg::w_axi_data / 8 - 1:0]  wstrb,
    input  logic                                    wvalid,
    output logic                                    wready,
    output logic [1:0]                              bresp,
    output logic                                    bvalid,
    input  logic                                    bready,
    input  logic [board_pkg::w_axi_addr - 1:0]      araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [board_pkg::w_axi_data - 1:0]      rdata,
    output logic [1:0]                              rresp,
    output logic                                    rvalid,
    input  logic                                    rready,

    output logic [board_pkg::w_led - 1:0]           led,
    output logic [board_pkg::w_seg - 1:0]           abcdefgh,
    output logic [board_pkg::w_digit - 1:0]         digit,

    output logic                                    mic_lr,
    output logic                                    mic_ws,
    output logic                                    mic_sck,
    input  logic                                    mic_sd
);

    localparam int w_value = 4 * board_pkg::w_digit;

    logic [w_value - 1:0]                display_value;
    logic [board_pkg::w_digit - 1:0]     dp_mask;
    logic                                source_mic;
    logic [board_pkg::w_mic - 1:0]       mic_value;
    logic [w_value - 1:0]                scan_value;   // What the display shows

    display_regs display_regs_inst
    (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .mic_value, .display_value, .dp_mask, .source_mic,
        .led_value ( led )
    );

    // Register value or the top bits of the last sample
    assign scan_value = source_mic ? mic_value[board_pkg::w_mic - 1 -: w_value] : display_value;

    seg7_scanner seg7_scanner_inst
    (
        .clk, .rst,
        .value    ( scan_value ),
        .dp_mask,
        .abcdefgh,
        .digit
    );

    inmp441_mic_i2s_receiver mic_inst
    (
        .clk, .rst,
        .lr    ( mic_lr    ),
        .ws    ( mic_ws    ),
        .sck   ( mic_sck   ),
        .sd    ( mic_sd    ),
        .value ( mic_value )
    );

endmodule

// File: seg7_scanner.sv
`timescale 1ns/1ps

module seg7_scanner
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [4 * board_pkg::w_digit - 1:0]  value,
    input  logic [board_pkg::w_digit - 1:0]      dp_mask,
    output logic [board_pkg::w_seg - 1:0]        abcdefgh,
    output logic [board_pkg::w_digit - 1:0]      digit
);

    localparam int w_div   = $clog2(board_pkg::scan_div);
    localparam int w_index = $clog2(board_pkg::w_digit);

    logic [w_div - 1:0]    div_cnt;   // Clocks spent on the current digit
    logic [w_index - 1:0]  index;     // Digit being shown
    logic [3:0]            nibble;
    logic [6:0]            segs;      // a in bit 6 down to g in bit 0

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            index   <= '0;
        end
        else if (div_cnt == w_div'(board_pkg::scan_div - 1))
        begin
            div_cnt <= '0;
            index   <= index + 1'b1;          // 0, 1, 2, 3 and around
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign nibble = value[index * 4 +: 4];

    // Hexadecimal font
    always_comb
    begin
        case (nibble)
            4'h0:    segs = 7'b1111110;
            4'h1:    segs = 7'b0110000;
            4'h2:    segs = 7'b1101101;
            4'h3:    segs = 7'b1111001;
            4'h4:    segs = 7'b0110011;
            4'h5:    segs = 7'b1011011;
            4'h6:    segs = 7'b1011111;
            4'h7:    segs = 7'b1110000;
            4'h8:    segs = 7'b1111111;
            4'h9:    segs = 7'b1111011;
            4'hA:    segs = 7'b1110111;
            4'hB:    segs = 7'b0011111;   // Lower case b
            4'hC:    segs = 7'b1001110;
            4'hD:    segs = 7'b0111101;   // Lower case d
            4'hE:    segs = 7'b1001111;
            default: segs = 7'b1000111;   // F
        endcase
    end

    assign abcdefgh = {segs, dp_mask[index]};
    assign digit    = board_pkg::w_digit'(1) << index;   // One-hot strobe

endmodule

// File: tb_board_specific_top.sv
`timescale 1ns/1ps

module tb_board_specific_top;

    logic        clk;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  led;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [6:0]  hex2;
    logic [6:0]  hex3;
    logic [3:0]  hex_dp;
    logic        mic_lr;
    logic        mic_ws;
    logic        mic_sck;
    logic        mic_sd    = 1'b0;
    logic [23:0] mic_word  = '0;       // Word the microphone model sends
    logic        prev_sck  = 1'b0;
    logic        prev_ws   = 1'b0;
    int          bit_idx   = 0;        // Bit clock index since ws fell
    int          n_cases   = 0;

    // Hex font in gfedcba order with segment a in bit 0
    logic [6:0]  font [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                               7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    board_specific_top board_specific_top_inst
    (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .led, .hex0, .hex1, .hex2, .hex3, .hex_dp,
        .mic_lr, .mic_ws, .mic_sck, .mic_sd
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;         // 8 ns period
    end

    // ------------------------------
    // Checks and bus tasks
    // ------------------------------

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall,
                             input logic [1:0] exp_resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(negedge clk);                // Taken on the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (stall)
        begin
            compare("bvalid", 32'(bvalid), 32'd1);   // Held under back-pressure
            compare("bresp", 32'(bresp), 32'(exp_resp));
            @(negedge clk);
        end
        compare("bvalid", 32'(bvalid), 32'd1);
        compare("bresp", 32'(bresp), 32'(exp_resp));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        compare("bvalid", 32'(bvalid), 32'd0);       // Response taken
    endtask

    task automatic read_reg(input logic [7:0] addr, input int stall,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        repeat (stall)
        begin
            compare("rvalid", 32'(rvalid), 32'd1);
            compare("rdata", rdata, exp_data);
            compare("rresp", 32'(rresp), 32'(exp_resp));
            @(negedge clk);
        end
        compare("rvalid", 32'(rvalid), 32'd1);
        compare("rdata", rdata, exp_data);
        compare("rresp", 32'(rresp), 32'(exp_resp));
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        compare("rvalid", 32'(rvalid), 32'd0);
    endtask

    // I2S microphone model drives data after each sck fall
    initial
    begin
        void'($urandom(84118));
        forever
        begin
            @(negedge clk);
            if (prev_sck && !mic_sck)
            begin
                bit_idx = (prev_ws && !mic_ws) ? 0 : bit_idx + 1;   // Restart on ws fall
                if (!mic_ws && bit_idx >= 1 && bit_idx <= 24)
                    mic_sd = mic_word[24 - bit_idx];                 // MSB after the delay bit
                else
                    mic_sd = 1'($urandom);                           // Padding
            end
            prev_sck = mic_sck;
            prev_ws  = mic_ws;
        end
    end

    initial
    begin
        wait (n_cases != 0);
        repeat (n_cases * 600) @(posedge clk);
        $display("Timeout: the case list did not finish in the allowed cycles");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------
    // Case runner
    // ------------------------------

    initial
    begin
        int          fd;
        int          n;
        string       line;
        string       lines [$];
        byte         op;
        logic [31:0] f1, f2, f3, f4, f5;

        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        fd = $fopen("board_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file board_cases.txt");
            $display("Done: errors found");
            $fatal(1, "Case file missing");
        end
        while ($fgets(line, fd) != 0)
            if (line.len() > 1 && line[0] != "#")
                lines.push_back(line);                // Skip comments and blank lines
        $fclose(fd);
        if (lines.size() == 0)
        begin
            $display("The case file holds no cases");
            $display("Done: errors found");
            $fatal(1, "Empty case file");
        end
        n_cases = lines.size();

        repeat (4) @(posedge clk);
        compare("led", 32'(led), 32'h0);              // Still in reset
        compare("hex0", 32'(hex0), 32'h7F);
        compare("hex1", 32'(hex1), 32'h7F);
        compare("hex2", 32'(hex2), 32'h7F);
        compare("hex3", 32'(hex3), 32'h7F);
        compare("hex_dp", 32'(hex_dp), 32'h0);
        compare("awready", 32'(awready), 32'h0);
        compare("wready", 32'(wready), 32'h0);
        compare("bvalid", 32'(bvalid), 32'h0);
        compare("arready", 32'(arready), 32'h0);
        compare("rvalid", 32'(rvalid), 32'h0);
        compare("mic_sck", 32'(mic_sck), 32'h0);
        compare("mic_ws", 32'(mic_ws), 32'h0);
        compare("mic_lr", 32'(mic_lr), 32'h0);
        @(negedge clk);
        rst = 1'b0;

        foreach (lines[i])
        begin
            op = lines[i][0];
            n  = $sscanf(lines[i].substr(2, lines[i].len() - 1), "%h %h %h %h %h",
                         f1, f2, f3, f4, f5);
            case (op)
                "W":
                begin
                    write_reg(f1[7:0], f2, f4[3:0], int'(f5), f3[1:0]);
                end
                "R":
                begin
                    read_reg(f1[7:0], int'(f4), f2, f3[1:0]);
                    if (f1[7:0] == 8'h10 && f3 == 32'h0)
                        compare("led", 32'(led), {24'h0, f2[7:0]});   // LED pins follow
                end
                "M":
                begin
                    mic_word = f1[23:0];
                    repeat (2) @(posedge mic_ws);    // One full left slot with the new word
                    compare("mic_lr", 32'(mic_lr), 32'h0);
                end
                "D":
                begin
                    repeat (40) @(negedge clk);      // Two scans and the sticky flops
                    compare("hex0", 32'(hex0), {25'h0, ~font[f1[3:0]]});
                    compare("hex1", 32'(hex1), {25'h0, ~font[f1[7:4]]});
                    compare("hex2", 32'(hex2), {25'h0, ~font[f1[11:8]]});
                    compare("hex3", 32'(hex3), {25'h0, ~font[f1[15:12]]});
                    compare("hex_dp", 32'(hex_dp), {28'h0, f2[3:0]});
                end
                default:
                begin
                    $display("Unknown operation in case line %0d, %0d fields", i, n);
                    $display("Done: errors found");
                    $fatal(1, "Bad case line");
                end
            endcase
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
